/* test/si570_i2c_init_tb.sv */
// testbench for si570_i2c_init, expected beats come from a walk of INIT_TABLE
// inputs change on the falling edge, handshakes are sampled on the rising edge
// four runs: readies high, random readies, held start, start pulse mid-run
`timescale 1ns/1ns
`default_nettype none

module si570_i2c_init_tb;

    localparam int CLK_PERIOD_NS = 10;
    localparam int RESET_CYCLES  = 2;
    // per run: every entry as two beats, 40 cycles each at worst
    localparam int RUN_CYCLES    = i2c_init_pkg::INIT_TABLE_LEN * 2 * 40;
    localparam int WATCHDOG_NS   = 4 * RUN_CYCLES * CLK_PERIOD_NS;
    localparam int IDLE_CYCLES   = 20;

    typedef enum int {M_RUN, M_SEEK, M_NEXT_ADDR, M_DATA} model_mode_t;

    logic                      clk;
    logic                      rst;
    logic                      start;
    logic                      cmd_ready;
    logic                      data_out_ready;
    i2c_master_pkg::i2c_addr_t cmd_address;
    logic                      cmd_start;
    logic                      cmd_write;
    logic                      cmd_stop;
    logic                      cmd_valid;
    i2c_master_pkg::i2c_byte_t data_out;
    logic                      data_out_valid;
    logic                      busy;

    // expected command beat as {address, start, write, stop}
    logic [9:0]  exp_cmd[$];
    logic [7:0]  exp_data[$];
    logic        random_ready;
    logic [31:0] lfsr_state;
    // held-beat tracking across one rising edge
    logic        cmd_held;
    logic [9:0]  cmd_held_word;
    logic        data_held;
    logic [7:0]  data_held_byte;
    int          value_errors;
    int          other_errors;
    int          cmd_beats;
    int          data_beats;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    si570_i2c_init i_si570_i2c_init (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .cmd_ready      (cmd_ready),
        .data_out_ready (data_out_ready),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy)
    );

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected) else begin
            value_errors++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    // walks the table by the decode rules and queues the beats of one run
    task automatic build_model;
        int          idx;
        int          data_ptr;
        int          addr_ptr;
        int          steps;
        logic [8:0]  e;
        logic [6:0]  cur_addr;
        logic [6:0]  latched_addr;
        logic        start_armed;
        logic        done;
        model_mode_t mode;
        exp_cmd.delete();
        exp_data.delete();
        idx = 0;
        data_ptr = 0;
        addr_ptr = 0;
        steps = 0;
        cur_addr = '0;
        latched_addr = '0;
        start_armed = 1'b0;
        done = 1'b0;
        mode = M_RUN;
        while (!done && steps < 1000 && idx < i2c_init_pkg::INIT_TABLE_LEN) begin
            e = i2c_init_pkg::INIT_TABLE[idx];
            steps++;
            if (e == i2c_init_pkg::OPC_END) begin
                exp_cmd.push_back({7'h00, 3'b001});
                done = 1'b1;
            end else if (e == i2c_init_pkg::OPC_DATA_BLOCK) begin
                data_ptr = idx + 1;
                idx++;
                mode = M_SEEK;
            end else if (e == i2c_init_pkg::OPC_EXIT_MULTI) begin
                // also the reserved case outside a block
                idx++;
                mode = M_RUN;
            end else if (mode == M_SEEK) begin
                if (e == i2c_init_pkg::OPC_ADDR_BLOCK) begin
                    addr_ptr = idx + 1;
                    mode = M_NEXT_ADDR;
                end
                idx++;
            end else if (mode == M_NEXT_ADDR) begin
                if (e[8:7] == 2'b01) begin
                    cur_addr = e[6:0];
                    addr_ptr = idx + 1;
                    idx = data_ptr;
                    mode = M_DATA;
                end else begin
                    idx++;
                end
            end else if (mode == M_DATA && e == i2c_init_pkg::OPC_ADDR_BLOCK) begin
                idx = addr_ptr;
                mode = M_NEXT_ADDR;
            end else begin
                if (e[8]) begin
                    exp_cmd.push_back({latched_addr, start_armed, 2'b10});
                    exp_data.push_back(e[7:0]);
                    start_armed = 1'b0;
                end else if (e[8:7] == 2'b01) begin
                    latched_addr = e[6:0];
                    start_armed = 1'b1;
                end else if (mode == M_DATA && e == i2c_init_pkg::OPC_WRITE_CUR) begin
                    latched_addr = cur_addr;
                    start_armed = 1'b1;
                end else if (e == i2c_init_pkg::OPC_SEND_STOP) begin
                    exp_cmd.push_back({7'h00, 3'b001});
                    start_armed = 1'b0;
                end
                idx++;
            end
        end
        assert (done) else begin
            other_errors++;
            $display("Error at %0t ns: table model never reached the end entry", $time);
        end
    endtask

    task automatic check_cmd_beat;
        logic [9:0] expected;
        assert (exp_cmd.size() != 0) else begin
            other_errors++;
            $display("Error at %0t ns: command beat accepted with none expected", $time);
        end
        if (exp_cmd.size() != 0) begin
            expected = exp_cmd.pop_front();
            // stop beats carry no address
            if (!expected[0]) begin
                check_value("cmd_address", 16'(cmd_address), 16'(expected[9:3]));
            end
            check_value("cmd_start", 16'(cmd_start), 16'(expected[2]));
            check_value("cmd_write", 16'(cmd_write), 16'(expected[1]));
            check_value("cmd_stop", 16'(cmd_stop), 16'(expected[0]));
        end
        cmd_beats++;
    endtask

    task automatic check_data_beat;
        logic [7:0] expected;
        assert (exp_data.size() != 0) else begin
            other_errors++;
            $display("Error at %0t ns: data beat accepted with none expected", $time);
        end
        if (exp_data.size() != 0) begin
            expected = exp_data.pop_front();
            check_value("data_out", 16'(data_out), 16'(expected));
        end
        data_beats++;
    endtask

    // readies: all high, or one LFSR step per bit
    always @(negedge clk) begin
        if (random_ready) begin
            lfsr_state = lfsr_next(lfsr_state);
            cmd_ready = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            data_out_ready = lfsr_state[0];
        end else begin
            cmd_ready = 1'b1;
            data_out_ready = 1'b1;
        end
    end

    // handshake monitor, reads values from before this edge's updates
    always @(posedge clk) begin
        if (rst) begin
            cmd_held = 1'b0;
            data_held = 1'b0;
        end else begin
            if (cmd_held) begin
                check_value("held cmd_valid", 16'(cmd_valid), 16'd1);
                check_value("held cmd beat", 16'({cmd_address, cmd_start, cmd_write, cmd_stop}),
                            16'(cmd_held_word));
            end
            if (data_held) begin
                check_value("held data_out_valid", 16'(data_out_valid), 16'd1);
                check_value("held data_out", 16'(data_out), 16'(data_held_byte));
            end
            if (cmd_valid && cmd_ready) begin
                check_cmd_beat();
            end
            if (data_out_valid && data_out_ready) begin
                check_data_beat();
            end
            cmd_held = cmd_valid && !cmd_ready;
            cmd_held_word = {cmd_address, cmd_start, cmd_write, cmd_stop};
            data_held = data_out_valid && !data_out_ready;
            data_held_byte = data_out;
        end
    end

    task automatic wait_for_busy(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (busy !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (busy === level) else begin
            other_errors++;
            $display("Error at %0t ns: busy did not go to %0b within %0d cycles",
                     $time, level, max_cycles);
        end
    endtask

    // nothing may move while the initializer is idle
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (cmd_valid === 1'b0 && data_out_valid === 1'b0 && busy === 1'b0) else begin
                other_errors++;
                $display("Error at %0t ns: output active while the initializer is idle", $time);
            end
        end
    endtask

    task automatic run_init(input logic rand_ready, input logic hold_start,
                            input logic mid_pulse);
        build_model();
        random_ready = rand_ready;
        @(negedge clk);
        start = 1'b1;
        if (!hold_start) begin
            @(negedge clk);
            start = 1'b0;
        end
        wait_for_busy(1'b1, 4);
        // second pulse inside the run, must be ignored
        if (mid_pulse) begin
            repeat (5) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        wait_for_busy(1'b0, RUN_CYCLES);
        assert (exp_cmd.size() == 0 && exp_data.size() == 0) else begin
            other_errors++;
            $display("Error at %0t ns: busy fell with %0d command and %0d data beats missing",
                     $time, exp_cmd.size(), exp_data.size());
        end
        // a held start must not trigger a second run here
        check_idle(IDLE_CYCLES);
        start = 1'b0;
    endtask

    task automatic report_counts;
        $display("errors: %0d value, %0d other; beats checked: %0d command, %0d data",
                 value_errors, other_errors, cmd_beats, data_beats);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Error at %0t ns: watchdog expired before the tests finished", $time);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        start = 1'b0;
        cmd_ready = 1'b0;
        data_out_ready = 1'b0;
        random_ready = 1'b0;
        lfsr_state = 32'hd88d_a1ab;
        value_errors = 0;
        other_errors = 0;
        cmd_beats = 0;
        data_beats = 0;
        wait (rst === 1'b0);
        // quiet after reset with start low
        check_idle(IDLE_CYCLES);
        run_init(1'b0, 1'b0, 1'b0);
        run_init(1'b1, 1'b0, 1'b0);
        run_init(1'b1, 1'b1, 1'b0);
        run_init(1'b1, 1'b0, 1'b1);
        check_idle(5);
        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// clock and reset for the testbench
// clk starts low, rst drops on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/i2c_master_pkg.sv
verilog/i2c_init_pkg.sv
verilog/init_table_rom.sv
verilog/init_sequencer.sv
verilog/i2c_cmd_issue.sv
verilog/si570_i2c_init.sv
test/tb_clock_gen.sv
test/si570_i2c_init_tb.sv

/* verilog/i2c_cmd_issue.sv */
// issue stage: command and data output registers toward the I2C master
// read, write-multiple and last are tied off at the master, not driven here
// a new operation is taken only once both channels are empty
`timescale 1ns/1ns
`default_nettype none

module i2c_cmd_issue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        op_valid,
    input  i2c_master_pkg::issue_op_t   op,
    input  i2c_master_pkg::i2c_addr_t   op_addr,
    input  i2c_master_pkg::i2c_byte_t   op_byte,
    input  logic                        cmd_ready,
    input  logic                        data_out_ready,
    output logic                        op_ready,
    output i2c_master_pkg::i2c_addr_t   cmd_address,
    output logic                        cmd_start,
    output logic                        cmd_write,
    output logic                        cmd_stop,
    output logic                        cmd_valid,
    output i2c_master_pkg::i2c_byte_t   data_out,
    output logic                        data_out_valid
);

    // set by an address op, consumed by the next write
    logic start_pending;
    logic op_fire;

    assign op_ready = !cmd_valid && !data_out_valid;
    assign op_fire  = op_valid && op_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_start      <= 1'b0;
            cmd_write      <= 1'b0;
            cmd_stop       <= 1'b0;
            cmd_valid      <= 1'b0;
            data_out_valid <= 1'b0;
            start_pending  <= 1'b0;
        end else begin
            // each channel drains on its own ready
            if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (data_out_ready) begin
                data_out_valid <= 1'b0;
            end
            // both valids are low whenever op_fire is set
            if (op_fire) begin
                case (op)
                    i2c_master_pkg::ISSUE_ADDR: begin
                        start_pending <= 1'b1;
                    end
                    i2c_master_pkg::ISSUE_WRITE: begin
                        cmd_start      <= start_pending;
                        cmd_write      <= 1'b1;
                        cmd_stop       <= 1'b0;
                        cmd_valid      <= 1'b1;
                        data_out_valid <= 1'b1;
                        start_pending  <= 1'b0;
                    end
                    i2c_master_pkg::ISSUE_STOP: begin
                        cmd_start     <= 1'b0;
                        cmd_write     <= 1'b0;
                        cmd_stop      <= 1'b1;
                        cmd_valid     <= 1'b1;
                        start_pending <= 1'b0;
                    end
                    default: begin
                        start_pending <= start_pending;
                    end
                endcase
            end
        end
    end

    // payload, only meaningful with its valid
    always_ff @(posedge clk) begin
        if (op_fire && op == i2c_master_pkg::ISSUE_ADDR) begin
            cmd_address <= op_addr;
        end
        if (op_fire && op == i2c_master_pkg::ISSUE_WRITE) begin
            data_out <= op_byte;
        end
    end

    // held beats do not move under back-pressure
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=>
            cmd_valid && $stable({cmd_address, cmd_start, cmd_write, cmd_stop})
    );

    a_data_stable: assert property (
        @(posedge clk) disable iff (rst)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out)
    );

    // a start never rides on a stop beat
    a_no_start_with_stop: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid |-> !(cmd_start && cmd_stop)
    );

endmodule

`default_nettype wire

/* verilog/i2c_init_pkg.sv */
// init table encoding and contents, fixed at build time
// table sets both I2C muxes as a multi-device block, then programs the Si570
// entry codes follow the 9-bit command format of the I2C master init
`default_nettype none

package i2c_init_pkg;

    localparam int ENTRY_W         = 9;
    localparam int INDEX_W         = 5;
    localparam int INIT_TABLE_LEN  = 30;

    typedef logic [ENTRY_W-1:0] init_entry_t;
    typedef logic [INDEX_W-1:0] init_index_t;

    // field positions
    // top bit set: data byte in the low eight bits
    localparam int ENTRY_DATA_BIT = ENTRY_W - 1;
    localparam int ENTRY_BYTE_MSB = 7;
    // top two bits 01: device address in the low seven bits
    localparam int ENTRY_TAG_MSB  = ENTRY_W - 1;
    localparam int ENTRY_TAG_LSB  = ENTRY_W - 2;
    localparam logic [1:0] ENTRY_TAG_ADDR = 2'b01;
    localparam int ENTRY_ADDR_MSB = 6;

    // table control codes, full 9-bit compare
    localparam init_entry_t OPC_END        = 9'd0;
    localparam init_entry_t OPC_EXIT_MULTI = 9'd1;
    localparam init_entry_t OPC_WRITE_CUR  = 9'd3;
    localparam init_entry_t OPC_ADDR_BLOCK = 9'd8;
    localparam init_entry_t OPC_DATA_BLOCK = 9'd9;
    localparam init_entry_t OPC_SEND_STOP  = 9'd65;

    localparam init_entry_t INIT_TABLE [INIT_TABLE_LEN] = '{
        // mux data block, run once per address below
        OPC_DATA_BLOCK, OPC_WRITE_CUR, {1'b1, 8'h00}, OPC_SEND_STOP,
        // mux addresses: U80 (0x75) then U28 (0x74)
        OPC_ADDR_BLOCK, {ENTRY_TAG_ADDR, 7'h75}, {ENTRY_TAG_ADDR, 7'h74}, OPC_EXIT_MULTI,
        // U28 connects output 0 to the Si570
        {ENTRY_TAG_ADDR, 7'h74}, {1'b1, 8'h01}, OPC_SEND_STOP,
        // reserved in single-device mode, skipped
        OPC_EXIT_MULTI,
        // freeze DCO
        {ENTRY_TAG_ADDR, 7'h5D}, {1'b1, 8'd137}, {1'b1, 8'h10},
        // HS_DIV, N1 and RFREQ from register 7 on
        {ENTRY_TAG_ADDR, 7'h5D}, {1'b1, 8'd7}, {1'b1, 8'h01}, {1'b1, 8'hC2},
        {1'b1, 8'hBC}, {1'b1, 8'h03}, {1'b1, 8'h51}, {1'b1, 8'h68},
        // unfreeze DCO
        {ENTRY_TAG_ADDR, 7'h5D}, {1'b1, 8'd137}, {1'b1, 8'h00},
        // apply new frequency
        {ENTRY_TAG_ADDR, 7'h5D}, {1'b1, 8'd135}, {1'b1, 8'h40},
        OPC_END
    };

endpackage

`default_nettype wire

/* verilog/i2c_master_pkg.sv */
// bus-side types shared by the sequencer and the issue stage
// 7-bit addressing only, no 10-bit address support
`default_nettype none

package i2c_master_pkg;

    // field widths on the I2C master command and data channels
    localparam int I2C_ADDR_W = 7;
    localparam int I2C_BYTE_W = 8;

    // device address, no r/w bit
    typedef logic [I2C_ADDR_W-1:0] i2c_addr_t;

    // one byte on the data channel
    typedef logic [I2C_BYTE_W-1:0] i2c_byte_t;

    // operation passed from sequencer to issue stage
    typedef enum logic [1:0] {
        // latch address, arm start for the next write
        ISSUE_ADDR  = 2'd0,
        // one write command plus its data byte
        ISSUE_WRITE = 2'd1,
        // stop command only
        ISSUE_STOP  = 2'd2
    } issue_op_t;

endpackage

`default_nettype wire

/* verilog/init_sequencer.sv */
// decode stage: walks the init table and hands operations to the issue stage
// start is edge triggered, held or repeated start during a run is ignored
// busy stays high until the issue stage has drained its last beat
`timescale 1ns/1ns
`default_nettype none

module init_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  i2c_init_pkg::init_entry_t   entry,
    input  logic                        op_ready,
    output i2c_init_pkg::init_index_t   next_index,
    output logic                        op_valid,
    output i2c_master_pkg::issue_op_t   op,
    output i2c_master_pkg::i2c_addr_t   op_addr,
    output i2c_master_pkg::i2c_byte_t   op_byte,
    output logic                        busy
);

    typedef enum logic [2:0] {
        ST_IDLE,
        // single-device commands
        ST_RUN,
        // data block seen, looking for its address block
        ST_SEEK_ADDR,
        // reading the next address of the block
        ST_NEXT_ADDR,
        // replaying the data block for cur_addr
        ST_DATA
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;

    // index of the entry currently on the entry input
    i2c_init_pkg::init_index_t index;
    i2c_init_pkg::init_index_t index_next;
    i2c_init_pkg::init_index_t index_inc;

    // first entry after the data block start / address block start
    i2c_init_pkg::init_index_t data_ptr;
    i2c_init_pkg::init_index_t data_ptr_next;
    i2c_init_pkg::init_index_t addr_ptr;
    i2c_init_pkg::init_index_t addr_ptr_next;

    i2c_master_pkg::i2c_addr_t cur_addr;
    i2c_master_pkg::i2c_addr_t cur_addr_next;

    logic start_flag;
    logic start_flag_next;

    // entry fields
    logic                      is_data;
    logic                      is_addr;
    i2c_master_pkg::i2c_addr_t entry_addr;
    i2c_master_pkg::i2c_byte_t entry_byte;

    assign is_data    = entry[i2c_init_pkg::ENTRY_DATA_BIT];
    assign is_addr    = entry[i2c_init_pkg::ENTRY_TAG_MSB:i2c_init_pkg::ENTRY_TAG_LSB]
                        == i2c_init_pkg::ENTRY_TAG_ADDR;
    assign entry_addr = entry[i2c_init_pkg::ENTRY_ADDR_MSB:0];
    assign entry_byte = entry[i2c_init_pkg::ENTRY_BYTE_MSB:0];

    assign index_inc  = i2c_init_pkg::init_index_t'(index + 1'b1);

    // rom reads at the next index, so entry follows it by one cycle
    assign next_index = index_next;

    always_comb begin
        state_next      = state;
        index_next      = index;
        data_ptr_next   = data_ptr;
        addr_ptr_next   = addr_ptr;
        cur_addr_next   = cur_addr;
        start_flag_next = start_flag;

        op_valid = 1'b0;
        op       = i2c_master_pkg::ISSUE_STOP;
        op_addr  = entry_addr;
        op_byte  = entry_byte;

        if (state == ST_IDLE) begin
            // wait for a fresh start and an empty issue stage
            if (start && !start_flag && op_ready) begin
                start_flag_next = 1'b1;
                index_next      = '0;
                state_next      = ST_RUN;
            end
        end else if (entry == i2c_init_pkg::OPC_END) begin
            // final stop, index stays on the end entry
            op_valid = 1'b1;
            op       = i2c_master_pkg::ISSUE_STOP;
            if (op_ready) begin
                state_next = ST_IDLE;
            end
        end else if (entry == i2c_init_pkg::OPC_DATA_BLOCK) begin
            // new data block from any state, go find its addresses
            data_ptr_next = index_inc;
            index_next    = index_inc;
            state_next    = ST_SEEK_ADDR;
        end else if (entry == i2c_init_pkg::OPC_EXIT_MULTI) begin
            // leave multi-device mode
            // in run state this is reserved, and skipping it lands in run anyway
            index_next = index_inc;
            state_next = ST_RUN;
        end else begin
            case (state)
                ST_RUN, ST_DATA: begin
                    if (is_data) begin
                        op_valid = 1'b1;
                        op       = i2c_master_pkg::ISSUE_WRITE;
                    end else if (is_addr) begin
                        op_valid = 1'b1;
                        op       = i2c_master_pkg::ISSUE_ADDR;
                    end else if (state == ST_DATA
                                 && entry == i2c_init_pkg::OPC_WRITE_CUR) begin
                        // substitute the address from the address block
                        op_valid = 1'b1;
                        op       = i2c_master_pkg::ISSUE_ADDR;
                        op_addr  = cur_addr;
                    end else if (entry == i2c_init_pkg::OPC_SEND_STOP) begin
                        op_valid = 1'b1;
                        op       = i2c_master_pkg::ISSUE_STOP;
                    end else if (state == ST_DATA
                                 && entry == i2c_init_pkg::OPC_ADDR_BLOCK) begin
                        // end of data block, fetch the next address
                        index_next = addr_ptr;
                        state_next = ST_NEXT_ADDR;
                    end else begin
                        // reserved code
                        index_next = index_inc;
                    end
                    // operations advance only when taken
                    if (op_valid && op_ready) begin
                        index_next = index_inc;
                    end
                end
                ST_SEEK_ADDR: begin
                    if (entry == i2c_init_pkg::OPC_ADDR_BLOCK) begin
                        addr_ptr_next = index_inc;
                        state_next    = ST_NEXT_ADDR;
                    end
                    // data block contents are skipped here
                    index_next = index_inc;
                end
                ST_NEXT_ADDR: begin
                    if (is_addr) begin
                        // remember address, jump back to the data block
                        cur_addr_next = entry_addr;
                        addr_ptr_next = index_inc;
                        index_next    = data_ptr;
                        state_next    = ST_DATA;
                    end else begin
                        index_next = index_inc;
                    end
                end
                default: begin
                    state_next = ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            index      <= '0;
            data_ptr   <= '0;
            addr_ptr   <= '0;
            start_flag <= 1'b0;
            busy       <= 1'b0;
        end else begin
            state      <= state_next;
            index      <= index_next;
            data_ptr   <= data_ptr_next;
            addr_ptr   <= addr_ptr_next;
            // cleared once start drops, so a held start fires only once
            start_flag <= start && start_flag_next;
            // one cycle late, held while a beat is still waiting downstream
            busy       <= (state != ST_IDLE) || !op_ready;
        end
    end

    // current device address, only read inside a data block
    always_ff @(posedge clk) begin
        cur_addr <= cur_addr_next;
    end

    // idle never offers an operation downstream
    a_no_op_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        state == ST_IDLE |-> !op_valid
    );

endmodule

`default_nettype wire

/* verilog/init_table_rom.sv */
// fetch stage: registered read of the init table
// entry lags next_index by one cycle, index 0 is shown during reset
`timescale 1ns/1ns
`default_nettype none

module init_table_rom (
    input  logic                        clk,
    input  logic                        rst,
    input  i2c_init_pkg::init_index_t   next_index,
    output i2c_init_pkg::init_entry_t   entry
);

    // one lookup per cycle, no enable
    // sequencer holds next_index steady when stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            // first entry ready as soon as reset drops
            entry <= i2c_init_pkg::INIT_TABLE[0];
        end else begin
            entry <= i2c_init_pkg::INIT_TABLE[next_index];
        end
    end

    // sequencer must never walk past the end entry
    a_index_in_range: assert property (
        @(posedge clk) disable iff (rst)
        next_index < i2c_init_pkg::INIT_TABLE_LEN
    );

endmodule

`default_nettype wire

/* verilog/si570_i2c_init.sv */
// I2C bus initializer for the Si570 clock path
// runs the fixed table in i2c_init_pkg once per rising start
// feeds an external I2C master, read and write-multiple tied off there
`timescale 1ns/1ns
`default_nettype none

module si570_i2c_init (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        cmd_ready,
    input  logic                        data_out_ready,
    output i2c_master_pkg::i2c_addr_t   cmd_address,
    output logic                        cmd_start,
    output logic                        cmd_write,
    output logic                        cmd_stop,
    output logic                        cmd_valid,
    output i2c_master_pkg::i2c_byte_t   data_out,
    output logic                        data_out_valid,
    output logic                        busy
);

    // fetch to sequencer
    i2c_init_pkg::init_index_t next_index;
    i2c_init_pkg::init_entry_t entry;

    // sequencer to issue
    logic                      op_valid;
    logic                      op_ready;
    i2c_master_pkg::issue_op_t op;
    i2c_master_pkg::i2c_addr_t op_addr;
    i2c_master_pkg::i2c_byte_t op_byte;

    init_table_rom i_init_table_rom (
        .clk        (clk),
        .rst        (rst),
        .next_index (next_index),
        .entry      (entry)
    );

    init_sequencer i_init_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .entry      (entry),
        .op_ready   (op_ready),
        .next_index (next_index),
        .op_valid   (op_valid),
        .op         (op),
        .op_addr    (op_addr),
        .op_byte    (op_byte),
        .busy       (busy)
    );

    i2c_cmd_issue i_i2c_cmd_issue (
        .clk            (clk),
        .rst            (rst),
        .op_valid       (op_valid),
        .op             (op),
        .op_addr        (op_addr),
        .op_byte        (op_byte),
        .cmd_ready      (cmd_ready),
        .data_out_ready (data_out_ready),
        .op_ready       (op_ready),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

endmodule

`default_nettype wire
